// ==== verilog/icache_pkg.sv ====
package icache_pkg;

    // geometry
    localparam int unsigned way_num     = 2;
    localparam int unsigned set_num     = 128;
    localparam int unsigned word_w      = 32;
    localparam int unsigned fetch_w     = 64;
    localparam int unsigned block_words = 8;

    // physical address split: tag | index | offset
    localparam int unsigned index_w    = $clog2(set_num);
    localparam int unsigned offset_w   = $clog2(block_words * word_w / 8);
    localparam int unsigned tag_w      = 32 - index_w - offset_w;

    // data RAM holds one doubleword per entry
    localparam int unsigned dw_index_w = index_w + $clog2(block_words * word_w / fetch_w);

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // element 1 is the instruction at pc+4
    typedef logic [fetch_w/word_w-1:0][word_w-1:0] fetch_t;

endpackage

// ==== verilog/array_wr_if.sv ====
`timescale 1ns/1ps

interface array_wr_if;

    logic [icache_pkg::way_num-1:0]    tag_we;
    logic [icache_pkg::way_num-1:0]    data_we;
    logic [icache_pkg::index_w-1:0]    wr_index;
    logic [icache_pkg::dw_index_w-1:0] wr_dw;
    icache_pkg::tag_entry_t            wr_tag;
    icache_pkg::fetch_t                wr_data;

    // refill and invalidate side
    modport ctrl (
        output tag_we, data_we, wr_index, wr_dw, wr_tag, wr_data
    );

    // RAM side
    modport array (
        input tag_we, data_we, wr_index, wr_dw, wr_tag, wr_data
    );

endinterface

// ==== verilog/sram_dp.sv ====
`timescale 1ns/1ps

module sram_dp #(
    parameter type         payload_t = logic [31:0],
    parameter int unsigned depth     = 128
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] rd_addr_i,
    input  logic                     rd_en_i,
    input  logic [$clog2(depth)-1:0] wr_addr_i,
    input  logic                     wr_en_i,
    input  payload_t                 wr_data_i,
    output payload_t                 rd_data_o,
    output payload_t                 wr_rd_data_o
);

    payload_t mem [depth];

    // read port holds its last value while disabled
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // write port, write-first
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
            wr_rd_data_o   <= wr_data_i;
        end else begin
            wr_rd_data_o   <= mem[wr_addr_i];
        end
    end

endmodule

// ==== verilog/icache_array.sv ====
`timescale 1ns/1ps

module icache_array (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [icache_pkg::index_w-1:0]    rd_index_i,
    input  logic [icache_pkg::dw_index_w-1:0] rd_dw_i,
    input  logic [icache_pkg::tag_w-1:0]      cmp_tag_i,
    array_wr_if.array                         wr,
    output logic [icache_pkg::way_num-1:0]    hit_o,
    output icache_pkg::fetch_t                rd_data_o
);

    logic [icache_pkg::set_num-1:0] valid_q [icache_pkg::way_num];
    logic [icache_pkg::index_w-1:0] rd_index_q;
    logic                           tag_conflict;
    logic                           tag_conflict_q;
    logic                           data_conflict;
    logic                           data_conflict_q;
    icache_pkg::fetch_t             way_data [icache_pkg::way_num];

    // same address on both ports, take the write port's result
    assign tag_conflict  = (rd_index_i == wr.wr_index);
    assign data_conflict = (rd_dw_i == wr.wr_dw);

    always_ff @(posedge clk) begin
        rd_index_q      <= rd_index_i;
        tag_conflict_q  <= tag_conflict;
        data_conflict_q <= data_conflict;
    end

    // valid bits live in flops so reset can clear them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < icache_pkg::way_num; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < icache_pkg::way_num; w++) begin
                if (wr.tag_we[w]) begin
                    valid_q[w][wr.wr_index] <= wr.wr_tag.valid;
                end
            end
        end
    end

    for (genvar w = 0; w < icache_pkg::way_num; w++) begin : g_way
        icache_pkg::tag_entry_t tag_rd;
        icache_pkg::tag_entry_t tag_fwd;
        icache_pkg::tag_entry_t tag_sel;
        icache_pkg::fetch_t     data_rd;
        icache_pkg::fetch_t     data_fwd;

        sram_dp #(
            .payload_t(icache_pkg::tag_entry_t),
            .depth    (icache_pkg::set_num)
        ) u_tag_ram (
            .clk         (clk),
            .rd_addr_i   (rd_index_i),
            .rd_en_i     (!tag_conflict),
            .wr_addr_i   (wr.wr_index),
            .wr_en_i     (wr.tag_we[w]),
            .wr_data_i   (wr.wr_tag),
            .rd_data_o   (tag_rd),
            .wr_rd_data_o(tag_fwd)
        );

        sram_dp #(
            .payload_t(icache_pkg::fetch_t),
            .depth    (1 << icache_pkg::dw_index_w)
        ) u_data_ram (
            .clk         (clk),
            .rd_addr_i   (rd_dw_i),
            .rd_en_i     (!data_conflict),
            .wr_addr_i   (wr.wr_dw),
            .wr_en_i     (wr.data_we[w]),
            .wr_data_i   (wr.wr_data),
            .rd_data_o   (data_rd),
            .wr_rd_data_o(data_fwd)
        );

        assign tag_sel     = tag_conflict_q ? tag_fwd : tag_rd;
        assign way_data[w] = data_conflict_q ? data_fwd : data_rd;
        assign hit_o[w]    = valid_q[w][rd_index_q] && tag_sel.valid
                             && (tag_sel.tag == cmp_tag_i);
    end

    // at most one way hits
    always_comb begin
        rd_data_o = '0;
        for (int w = 0; w < icache_pkg::way_num; w++) begin
            if (hit_o[w]) begin
                rd_data_o = way_data[w];
            end
        end
    end

endmodule

// ==== verilog/way_select.sv ====
`timescale 1ns/1ps

module way_select (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [icache_pkg::index_w-1:0]         index_i,
    input  logic                                   toggle_i,
    output logic [$clog2(icache_pkg::way_num)-1:0] victim_o
);

    // one bit per set, names the way to evict next
    logic [icache_pkg::set_num-1:0] way_q;

    assign victim_o = way_q[index_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            way_q <= '0;
        end else if (toggle_i) begin
            way_q[index_i] <= ~way_q[index_i];
        end
    end

endmodule

// ==== verilog/refill_ctrl.sv ====
`timescale 1ns/1ps

module refill_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   flush_i,
    input  logic                                   fetch_valid_i,
    input  logic [31:0]                            pc_i,
    input  logic [1:0]                             mask_i,
    input  logic [icache_pkg::way_num-1:0]         hit_i,
    input  icache_pkg::fetch_t                     rd_data_i,
    input  logic [$clog2(icache_pkg::way_num)-1:0] victim_i,
    input  logic                                   mem_ack_i,
    input  logic                                   mem_data_valid_i,
    input  logic [icache_pkg::word_w-1:0]          mem_data_i,
    input  logic                                   inv_valid_i,
    input  logic [icache_pkg::index_w-1:0]         inv_index_i,
    input  logic [$clog2(icache_pkg::way_num)-1:0] inv_way_i,
    output logic                                   fetch_ready_o,
    output logic                                   out_valid_o,
    output logic [31:0]                            out_pc_o,
    output icache_pkg::fetch_t                     out_insts_o,
    output logic                                   mem_req_o,
    output logic [31:0]                            mem_addr_o,
    output logic [3:0]                             mem_len_o,
    output logic                                   inv_done_o,
    output logic [icache_pkg::index_w-1:0]         rd_index_o,
    output logic [icache_pkg::dw_index_w-1:0]      rd_dw_o,
    output logic [icache_pkg::tag_w-1:0]           cmp_tag_o,
    output logic                                   toggle_o,
    array_wr_if.ctrl                               wr
);

    typedef enum logic [1:0] {
        s_normal,
        s_request,
        s_receive,
        s_deliver
    } state_e;

    state_e                                     state_q;
    state_e                                     state_d;
    logic                                       valid_q;
    logic [31:0]                                pc_q;
    logic [1:0]                                 mask_q;
    logic [31:0]                                miss_pc;
    logic                                       miss_live_q;
    logic [$clog2(icache_pkg::block_words)-1:0] word_cnt_q;
    logic [icache_pkg::word_w-1:0]              lo_q;
    icache_pkg::fetch_t                         fill_q;
    logic                                       normal;
    logic                                       miss_now;
    logic                                       start_miss;
    logic                                       pair_wr;
    logic                                       last_wr;
    logic [31:0]                                rd_pc;
    logic [31:0]                                block_pc;
    logic [icache_pkg::index_w-1:0]             miss_index;
    logic [icache_pkg::way_num-1:0]             victim_oh;
    logic [icache_pkg::way_num-1:0]             inv_oh;

    assign normal     = (state_q == s_normal);
    // zero mask never counts as a miss
    assign miss_now   = valid_q && (|mask_q) && !(|hit_i) && !flush_i;
    assign start_miss = normal && miss_now && !inv_valid_i;

    // an invalidate wins, so the missed fetch waits in stage two
    assign fetch_ready_o = normal && !(miss_now && inv_valid_i);
    assign inv_done_o    = normal && inv_valid_i;

    // read the held pc while stalled
    assign rd_pc      = fetch_ready_o ? pc_i : pc_q;
    assign rd_index_o = rd_pc[icache_pkg::offset_w +: icache_pkg::index_w];
    assign rd_dw_o    = rd_pc[$clog2(icache_pkg::fetch_w / 8) +: icache_pkg::dw_index_w];
    assign cmp_tag_o  = pc_q[31 -: icache_pkg::tag_w];
    assign miss_index = miss_pc[icache_pkg::offset_w +: icache_pkg::index_w];

    // memory request
    assign block_pc   = normal ? pc_q : miss_pc;
    assign mem_addr_o = {block_pc[31:icache_pkg::offset_w], {icache_pkg::offset_w{1'b0}}};
    assign mem_len_o  = 4'(icache_pkg::block_words);
    assign mem_req_o  = start_miss || (state_q == s_request);

    // odd word completes a doubleword
    assign pair_wr  = (state_q == s_receive) && mem_data_valid_i && word_cnt_q[0];
    assign last_wr  = pair_wr && (&word_cnt_q);
    assign toggle_o = last_wr;

    assign out_valid_o = normal ? (valid_q && (|mask_q) && (|hit_i) && !flush_i)
                                : ((state_q == s_deliver) && miss_live_q && !flush_i);
    assign out_pc_o    = normal ? pc_q : miss_pc;
    assign out_insts_o = normal ? rd_data_i : fill_q;

    // array write port, shared by invalidate and refill
    always_comb begin
        victim_oh           = '0;
        victim_oh[victim_i] = 1'b1;
        inv_oh              = '0;
        inv_oh[inv_way_i]   = 1'b1;
        wr.wr_data          = {mem_data_i, lo_q};
        wr.wr_dw            = {miss_index, word_cnt_q[$bits(word_cnt_q)-1:1]};
        if (normal) begin
            wr.tag_we   = inv_valid_i ? inv_oh : '0;
            wr.data_we  = '0;
            wr.wr_index = inv_index_i;
            wr.wr_tag   = '0;
        end else begin
            wr.tag_we   = last_wr ? victim_oh : '0;
            wr.data_we  = pair_wr ? victim_oh : '0;
            wr.wr_index = miss_index;
            wr.wr_tag   = '{valid: 1'b1, tag: miss_pc[31 -: icache_pkg::tag_w]};
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_normal: begin
                if (start_miss) begin
                    state_d = mem_ack_i ? s_receive : s_request;
                end
            end
            s_request: begin
                if (mem_ack_i) begin
                    state_d = s_receive;
                end
            end
            s_receive: begin
                if (last_wr) begin
                    state_d = s_deliver;
                end
            end
            default: begin
                state_d = s_normal;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= s_normal;
            valid_q     <= 1'b0;
            miss_live_q <= 1'b0;
            word_cnt_q  <= '0;
        end else begin
            state_q <= state_d;
            if (flush_i) begin
                valid_q <= 1'b0;
            end else if (fetch_ready_o) begin
                valid_q <= fetch_valid_i;
            end else if (state_q == s_deliver) begin
                // missed fetch is answered by the delivery itself
                valid_q <= 1'b0;
            end
            // a flush during refill drops the delivery
            if (start_miss) begin
                miss_live_q <= 1'b1;
            end else if (flush_i) begin
                miss_live_q <= 1'b0;
            end
            // wraps to zero after the last word
            if ((state_q == s_receive) && mem_data_valid_i) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ready_o) begin
            pc_q   <= pc_i;
            mask_q <= mask_i;
        end
        if (start_miss) begin
            miss_pc <= pc_q;
        end
        if ((state_q == s_receive) && mem_data_valid_i && !word_cnt_q[0]) begin
            lo_q <= mem_data_i;
        end
        // keep the requested doubleword for delivery
        if (pair_wr && (word_cnt_q[$bits(word_cnt_q)-1:1]
                        == miss_pc[icache_pkg::offset_w-1:$clog2(icache_pkg::fetch_w / 8)])) begin
            fill_q <= {mem_data_i, lo_q};
        end
    end

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   flush_i,
    // fetch side
    input  logic                                   fetch_valid_i,
    input  logic [31:0]                            pc_i,
    input  logic [1:0]                             mask_i,
    output logic                                   fetch_ready_o,
    // decoder side
    output logic                                   out_valid_o,
    output logic [31:0]                            out_pc_o,
    output logic [icache_pkg::fetch_w-1:0]         out_insts_o,
    // memory side
    output logic                                   mem_req_o,
    output logic [31:0]                            mem_addr_o,
    output logic [3:0]                             mem_len_o,
    input  logic                                   mem_ack_i,
    input  logic                                   mem_data_valid_i,
    input  logic [icache_pkg::word_w-1:0]          mem_data_i,
    // index invalidate
    input  logic                                   inv_valid_i,
    input  logic [icache_pkg::index_w-1:0]         inv_index_i,
    input  logic [$clog2(icache_pkg::way_num)-1:0] inv_way_i,
    output logic                                   inv_done_o
);

    array_wr_if wr_if ();

    logic [icache_pkg::way_num-1:0]         hit;
    icache_pkg::fetch_t                     rd_data;
    logic [icache_pkg::index_w-1:0]         rd_index;
    logic [icache_pkg::dw_index_w-1:0]      rd_dw;
    logic [icache_pkg::tag_w-1:0]           cmp_tag;
    logic [$clog2(icache_pkg::way_num)-1:0] victim;
    logic                                   toggle;

    refill_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush_i),
        .fetch_valid_i   (fetch_valid_i),
        .pc_i            (pc_i),
        .mask_i          (mask_i),
        .hit_i           (hit),
        .rd_data_i       (rd_data),
        .victim_i        (victim),
        .mem_ack_i       (mem_ack_i),
        .mem_data_valid_i(mem_data_valid_i),
        .mem_data_i      (mem_data_i),
        .inv_valid_i     (inv_valid_i),
        .inv_index_i     (inv_index_i),
        .inv_way_i       (inv_way_i),
        .fetch_ready_o   (fetch_ready_o),
        .out_valid_o     (out_valid_o),
        .out_pc_o        (out_pc_o),
        .out_insts_o     (out_insts_o),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_len_o       (mem_len_o),
        .inv_done_o      (inv_done_o),
        .rd_index_o      (rd_index),
        .rd_dw_o         (rd_dw),
        .cmp_tag_o       (cmp_tag),
        .toggle_o        (toggle),
        .wr              (wr_if.ctrl)
    );

    icache_array u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index_i(rd_index),
        .rd_dw_i   (rd_dw),
        .cmp_tag_i (cmp_tag),
        .wr        (wr_if.array),
        .hit_o     (hit),
        .rd_data_o (rd_data)
    );

    // victim is looked up at the set under refill
    way_select u_way_select (
        .clk     (clk),
        .rst_n   (rst_n),
        .index_i (wr_if.wr_index),
        .toggle_i(toggle),
        .victim_o(victim)
    );

endmodule

// ==== bench/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;

    localparam int num_tests   = 5;
    localparam int drain_limit = 200;

    logic        clk;
    logic        rst_n;
    logic        flush_i;
    logic        fetch_valid_i;
    logic [31:0] pc_i;
    logic [1:0]  mask_i;
    logic        fetch_ready_o;
    logic        out_valid_o;
    logic [31:0] out_pc_o;
    logic [63:0] out_insts_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic [3:0]  mem_len_o;
    logic        mem_ack_i;
    logic        mem_data_valid_i;
    logic [31:0] mem_data_i;
    logic        inv_valid_i;
    logic [6:0]  inv_index_i;
    logic        inv_way_i;
    logic        inv_done_o;

    integer      seed = 4;
    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          test_err_start = 0;
    int          req_count = 0;
    int          out_count = 0;
    logic [31:0] last_addr;
    logic [3:0]  last_len;
    // pcs of accepted fetches still waiting for out_valid_o
    logic [31:0] exp_q [$];

    icache_top dut0 (.*);

    always #50 clk = ~clk;

    // memory content at a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'hC0DE0000;
    endfunction

    // pc+4 in the upper half
    function automatic logic [63:0] expect_insts(input logic [31:0] pc);
        return {mem_word(pc + 32'd4), mem_word(pc)};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_count - test_err_start;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: passed", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, errs);
        end
        test_err_start = err_count;
    endtask

    // hold the request until fetch_ready_o was high at an edge
    task automatic send_fetch(input logic [31:0] pc, input logic [1:0] mask,
                              input bit expect_out);
        bit accepted;
        @(negedge clk);
        fetch_valid_i = 1'b1;
        pc_i          = pc;
        mask_i        = mask;
        accepted      = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = fetch_ready_o;
        end
        if (expect_out) begin
            exp_q.push_back(pc);
        end
    endtask

    task automatic idle_fetch();
        @(negedge clk);
        fetch_valid_i = 1'b0;
        mask_i        = 2'b00;
    endtask

    task automatic wait_outputs();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < drain_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            err_count++;
            $display("no output for pc %h within %0d cycles", exp_q[0], drain_limit);
            exp_q.delete();
        end
    endtask

    task automatic fetch_and_count(input logic [31:0] pc, input int exp_reqs);
        int reqs_before;
        reqs_before = req_count;
        send_fetch(pc, 2'b11, 1'b1);
        idle_fetch();
        wait_outputs();
        check_value("mem_req_o count", req_count - reqs_before, exp_reqs);
        if (exp_reqs != 0) begin
            check_value("mem_addr_o", last_addr, pc & ~32'h1F);
            check_value("mem_len_o", last_len, 8);
        end
    endtask

    task automatic invalidate(input logic [6:0] index, input logic way);
        @(negedge clk);
        inv_valid_i = 1'b1;
        inv_index_i = index;
        inv_way_i   = way;
        @(posedge clk);
        check_value("inv_done_o", inv_done_o, 1'b1);
        @(negedge clk);
        inv_valid_i = 1'b0;
    endtask

    // compares every delivered doubleword with the oldest pending fetch
    always @(posedge clk) begin : monitor
        logic [31:0] exp_pc;
        if (rst_n && out_valid_o === 1'b1) begin
            out_count++;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("out_valid_o raised for pc %h with no fetch pending", out_pc_o);
            end else begin
                exp_pc = exp_q.pop_front();
                check_value("out_pc_o", out_pc_o, exp_pc);
                check_value("out_insts_o", out_insts_o, expect_insts(exp_pc));
            end
        end
    end

    // answers a request after 0 to 3 cycles, then eight words with gaps
    always begin : mem_model
        int delay;
        int gap;
        int i;
        @(posedge clk);
        if (rst_n && mem_req_o === 1'b1) begin
            req_count++;
            last_addr = mem_addr_o;
            last_len  = mem_len_o;
            delay     = {$random(seed)} % 4;
            @(negedge clk);
            repeat (delay) @(negedge clk);
            mem_ack_i = 1'b1;
            @(negedge clk);
            mem_ack_i = 1'b0;
            for (i = 0; i < 8; i++) begin
                gap = {$random(seed)} % 3;
                repeat (gap) @(negedge clk);
                mem_data_valid_i = 1'b1;
                mem_data_i       = mem_word(last_addr + 32'(4 * i));
                @(negedge clk);
                mem_data_valid_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (num_tests * 400) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", num_tests * 400);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int outs_before;
        int reqs_before;
        clk              = 1'b0;
        rst_n            = 1'b0;
        flush_i          = 1'b0;
        fetch_valid_i    = 1'b0;
        pc_i             = '0;
        mask_i           = 2'b00;
        mem_ack_i        = 1'b0;
        mem_data_valid_i = 1'b0;
        mem_data_i       = '0;
        inv_valid_i      = 1'b0;
        inv_index_i      = '0;
        inv_way_i        = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle levels right after reset
        check_value("fetch_ready_o", fetch_ready_o, 1'b1);
        check_value("mem_req_o", mem_req_o, 1'b0);
        check_value("out_valid_o", out_valid_o, 1'b0);
        check_value("inv_done_o", inv_done_o, 1'b0);

        // set 0x23, doubleword 1 of the block
        fetch_and_count(32'h0000_2468, 1);
        finish_test("cold miss");

        outs_before = out_count;
        reqs_before = req_count;
        send_fetch(32'h0000_2460, 2'b11, 1'b1);
        send_fetch(32'h0000_2468, 2'b11, 1'b1);
        send_fetch(32'h0000_2470, 2'b11, 1'b1);
        send_fetch(32'h0000_2478, 2'b11, 1'b1);
        idle_fetch();
        wait_outputs();
        check_value("out_valid_o count", out_count - outs_before, 4);
        check_value("mem_req_o count", req_count - reqs_before, 0);
        finish_test("hits in refilled block");

        // three tags in set 0x10, C lands in way 0 over A
        fetch_and_count(32'h0001_0200, 1);
        fetch_and_count(32'h0002_0200, 1);
        fetch_and_count(32'h0003_0200, 1);
        fetch_and_count(32'h0002_0200, 0);
        fetch_and_count(32'h0001_0200, 1);
        finish_test("replacement");

        // first refill of set 0x23 went to way 0
        invalidate(7'h23, 1'b0);
        fetch_and_count(32'h0000_2468, 1);
        finish_test("invalidation");

        reqs_before = req_count;
        outs_before = out_count;
        send_fetch(32'h0000_2470, 2'b11, 1'b0);
        @(negedge clk);
        fetch_valid_i = 1'b0;
        flush_i       = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        repeat (5) @(negedge clk);
        // uncached pc with an empty mask
        send_fetch(32'h0009_0000, 2'b00, 1'b0);
        idle_fetch();
        repeat (10) @(negedge clk);
        check_value("out_valid_o count", out_count - outs_before, 0);
        check_value("mem_req_o count", req_count - reqs_before, 0);
        finish_test("flush and zero mask");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/icache_pkg.sv
verilog/array_wr_if.sv
verilog/sram_dp.sv
verilog/icache_array.sv
verilog/way_select.sv
verilog/refill_ctrl.sv
verilog/icache_top.sv
bench/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/array_wr_if.sv
      - verilog/sram_dp.sv
      - verilog/icache_array.sv
      - verilog/way_select.sv
      - verilog/refill_ctrl.sv
      - verilog/icache_top.sv
  - target: test
    files:
      - bench/tb_icache.sv
